//--- design/motion_defs.svh
`ifndef MOTION_DEFS_SVH
`define MOTION_DEFS_SVH

// SPI word width in bits
`define WORD_W 64

// Move queue entries, power of two
`define MOVE_DEPTH 4
`define MOVE_IDX_W 2

// Subtracted from the DDA accumulator on each step
`define DDA_THRESHOLD 64'h7FFF_FFFF_FFFF_FF9B

// Reported API version
`define VER_MAJOR 8'd0
`define VER_MINOR 8'd1
`define VER_PATCH 8'd0

// CLK cycles per DDA tick after reset
`define DIV_RESET 8'd40

`endif

//--- design/motion_pkg.sv
`default_nettype none

`include "motion_defs.svh"

package motion_pkg;

  // Move length in DDA ticks
  typedef logic [`WORD_W-1:0] duration_t;

  // Signed step rate and accumulator
  typedef logic signed [`WORD_W-1:0] rate_t;

  // Signed encoder position
  typedef logic signed [`WORD_W-1:0] enc_count_t;

  // CLK cycles per DDA tick
  typedef logic [7:0] divisor_t;

  // Microstep mode, 2 is half step
  typedef logic [2:0] ustep_t;

  // Planner sequencing
  typedef enum logic {DDA_IDLE, DDA_RUN} dda_state_e;

endpackage

`default_nettype wire

//--- design/host_pkg.sv
`default_nettype none

`include "motion_defs.svh"

package host_pkg;

  // One SPI transfer
  typedef logic [`WORD_W-1:0] word_t;

  // Command byte from the top of a word
  typedef logic [7:0] header_t;

  typedef enum logic [7:0] {
    CMD_COORD_STEP   = 8'h01,
    CMD_MOTOR_ENABLE = 8'h0A,
    CMD_CLK_DIVISOR  = 8'h0B,
    CMD_MICROSTEPS   = 8'h0C,
    CMD_API_VERSION  = 8'hFE
  } cmd_e;

  // Word expected next by the decoder
  typedef enum logic [2:0] {DEC_HEADER, DEC_DURATION, DEC_INCR, DEC_INCR2, DEC_TRAILER} dec_state_e;

endpackage

`default_nettype wire

//--- design/move_if.sv
`timescale 1ns/1ps
`default_nettype none

// One queued move, decoder to planner
interface move_if;

  // Push strobe, one cycle per move
  logic wr;
  // Direction from header bit 0
  logic dir;
  motion_pkg::duration_t duration;
  motion_pkg::rate_t increment;
  motion_pkg::rate_t increment2;
  // Queue has no free entry
  logic full;

  modport source (output wr, output dir, output duration, output increment,
                  output increment2, input full);

  modport sink (input wr, input dir, input duration, input increment,
                input increment2, output full);

endinterface

`default_nettype wire

//--- design/spi_word_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_defs.svh"

module spi_word_rx (
  input  wire logic CLK,
  input  wire logic reset,
  input  wire logic sck,
  input  wire logic cs,
  input  wire logic copi,
  output logic cipo,
  input  wire host_pkg::word_t tx_word,
  output host_pkg::word_t rx_word,
  output logic word_valid
);

  localparam int CNT_W = $clog2(`WORD_W);

  // Two sync flops, third stage for edge detect
  logic [2:0] sck_s;
  logic [2:0] cs_s;
  logic [1:0] copi_s;
  logic [CNT_W-1:0] bit_cnt;
  host_pkg::word_t rx_shift;
  host_pkg::word_t tx_shift;
  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  logic cs_active;

  assign sck_rise = sck_s[1] & ~sck_s[2];
  assign sck_fall = ~sck_s[1] & sck_s[2];
  assign cs_fall = ~cs_s[1] & cs_s[2];
  assign cs_active = ~cs_s[1];

  // Bit counting and word strobe
  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_s <= '0;
      cs_s <= '1;
      bit_cnt <= '0;
      word_valid <= 1'b0;
    end else begin
      sck_s <= {sck_s[1:0], sck};
      cs_s <= {cs_s[1:0], cs};
      word_valid <= 1'b0;
      // Deselect restarts the frame
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        // 64th bit just captured
        if (bit_cnt == CNT_W'(`WORD_W - 1)) begin
          word_valid <= 1'b1;
        end
      end
    end
  end

  // Data shifters, MSB first both ways
  always_ff @(posedge CLK) begin
    copi_s <= {copi_s[0], copi};
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[`WORD_W-2:0], copi_s[1]};
    end
    // Reply word latched at frame start
    if (cs_fall) begin
      tx_shift <= tx_word;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[`WORD_W-2:0], 1'b0};
    end
  end

  assign cipo = tx_shift[`WORD_W-1];
  assign rx_word = rx_shift;

  // Host holds CS low until well past the last rise
  assert property (@(posedge CLK) disable iff (reset) word_valid |-> !cs);

endmodule

`default_nettype wire

//--- design/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_defs.svh"

module cmd_decoder (
  input  wire logic CLK,
  input  wire logic reset,
  input  wire logic word_valid,
  input  wire host_pkg::word_t rx_word,
  output host_pkg::word_t tx_word,
  move_if.source mv,
  output motion_pkg::divisor_t divisor,
  output logic enable,
  output motion_pkg::ustep_t microsteps,
  input  wire motion_pkg::enc_count_t enc_count,
  input  wire motion_pkg::enc_count_t enc_last
);

  host_pkg::dec_state_e state;
  host_pkg::header_t header;
  // Reply overrides for the next word out
  logic reply_ver;
  logic reply_last;

  assign header = rx_word[`WORD_W-1 -: 8];

  // Sequencing and configuration
  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= host_pkg::DEC_HEADER;
      reply_ver <= 1'b0;
      reply_last <= 1'b0;
      mv.wr <= 1'b0;
      enable <= 1'b0;
      divisor <= `DIV_RESET;
      microsteps <= 3'd1;
    end else begin
      mv.wr <= 1'b0;
      if (word_valid) begin
        // Live encoder count unless overridden below
        reply_ver <= 1'b0;
        reply_last <= 1'b0;
        case (state)
          host_pkg::DEC_HEADER: begin
            case (host_pkg::cmd_e'(header))
              host_pkg::CMD_COORD_STEP:   state <= host_pkg::DEC_DURATION;
              host_pkg::CMD_MOTOR_ENABLE: enable <= rx_word[0];
              host_pkg::CMD_CLK_DIVISOR:  divisor <= rx_word[7:0];
              host_pkg::CMD_MICROSTEPS:   microsteps <= rx_word[2:0];
              host_pkg::CMD_API_VERSION: begin
                reply_ver <= 1'b1;
                state <= host_pkg::DEC_TRAILER;
              end
              // Unknown headers dropped
              default: state <= host_pkg::DEC_HEADER;
            endcase
          end
          host_pkg::DEC_DURATION: begin
            reply_last <= 1'b1;
            state <= host_pkg::DEC_INCR;
          end
          host_pkg::DEC_INCR: state <= host_pkg::DEC_INCR2;
          host_pkg::DEC_INCR2: begin
            mv.wr <= 1'b1;
            state <= host_pkg::DEC_HEADER;
          end
          // Version trailer content ignored
          default: state <= host_pkg::DEC_HEADER;
        endcase
      end
    end
  end

  // Move fields collected word by word
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      case (state)
        host_pkg::DEC_HEADER:   mv.dir <= rx_word[0];
        host_pkg::DEC_DURATION: mv.duration <= rx_word;
        host_pkg::DEC_INCR:     mv.increment <= rx_word;
        host_pkg::DEC_INCR2:    mv.increment2 <= rx_word;
        default:                mv.dir <= mv.dir;
      endcase
    end
  end

  // Reply word, follows encoder live by default
  always_comb begin
    if (reply_ver) begin
      tx_word = {{(`WORD_W-24){1'b0}}, `VER_MAJOR, `VER_MINOR, `VER_PATCH};
    end else if (reply_last) begin
      tx_word = enc_last;
    end else begin
      tx_word = enc_count;
    end
  end

  // No back-pressure, host must respect queue depth
  assert property (@(posedge CLK) disable iff (reset) mv.wr |-> !mv.full);

endmodule

`default_nettype wire

//--- design/step_planner.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_defs.svh"

module step_planner (
  input  wire logic CLK,
  input  wire logic reset,
  move_if.sink mv,
  input  wire motion_pkg::divisor_t divisor,
  input  wire motion_pkg::enc_count_t enc_count,
  output motion_pkg::enc_count_t enc_last,
  output logic step,
  output logic dir
);

  // Circular move queue
  logic q_dir [`MOVE_DEPTH];
  motion_pkg::duration_t q_duration [`MOVE_DEPTH];
  motion_pkg::rate_t q_incr [`MOVE_DEPTH];
  motion_pkg::rate_t q_incr2 [`MOVE_DEPTH];
  // Extra top bit tells full from empty
  logic [`MOVE_IDX_W:0] wr_ptr;
  logic [`MOVE_IDX_W:0] rd_ptr;
  logic [`MOVE_IDX_W-1:0] wr_idx;
  logic [`MOVE_IDX_W-1:0] rd_idx;
  logic empty;

  // Active move and DDA
  motion_pkg::dda_state_e state;
  motion_pkg::divisor_t clk_cnt;
  motion_pkg::duration_t ticks_left;
  motion_pkg::rate_t act_incr2;
  motion_pkg::rate_t rate;
  motion_pkg::rate_t rate_next;
  motion_pkg::rate_t acc;
  motion_pkg::rate_t acc_sum;
  logic act_dir;
  logic tick;

  assign wr_idx = wr_ptr[`MOVE_IDX_W-1:0];
  assign rd_idx = rd_ptr[`MOVE_IDX_W-1:0];
  assign empty = (wr_ptr == rd_ptr);
  assign mv.full = (wr_ptr[`MOVE_IDX_W] != rd_ptr[`MOVE_IDX_W]) && (wr_idx == rd_idx);

  assign tick = (state == motion_pkg::DDA_RUN) && (clk_cnt == divisor);
  assign rate_next = rate + act_incr2;
  assign acc_sum = acc + rate_next;
  // Step in the tick cycle itself
  assign step = tick && (acc_sum > 0);
  assign dir = act_dir;

  // Queue storage and active move fields
  always_ff @(posedge CLK) begin
    if (mv.wr) begin
      q_dir[wr_idx] <= mv.dir;
      q_duration[wr_idx] <= mv.duration;
      q_incr[wr_idx] <= mv.increment;
      q_incr2[wr_idx] <= mv.increment2;
    end
    if (state == motion_pkg::DDA_IDLE && !empty) begin
      act_dir <= q_dir[rd_idx];
      act_incr2 <= q_incr2[rd_idx];
      ticks_left <= q_duration[rd_idx];
      // Pre-biased so the first tick yields increment
      rate <= q_incr[rd_idx] - q_incr2[rd_idx];
    end else if (tick) begin
      rate <= rate_next;
      ticks_left <= ticks_left - 1'b1;
    end
  end

  // Pointers, tick divider and accumulator
  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      state <= motion_pkg::DDA_IDLE;
      clk_cnt <= 8'd1;
      acc <= '0;
      enc_last <= '0;
    end else begin
      if (mv.wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      case (state)
        motion_pkg::DDA_IDLE: begin
          if (!empty) begin
            rd_ptr <= rd_ptr + 1'b1;
            clk_cnt <= 8'd1;
            state <= motion_pkg::DDA_RUN;
          end
        end
        default: begin
          if (tick) begin
            clk_cnt <= 8'd1;
            enc_last <= enc_count;
            // Accumulator carries across moves
            acc <= step ? acc_sum - motion_pkg::rate_t'(`DDA_THRESHOLD) : acc_sum;
            // Duration+1 ticks per move
            if (ticks_left == '0) begin
              state <= motion_pkg::DDA_IDLE;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Divisor must not drop below the running count
  assert property (@(posedge CLK) disable iff (reset)
    (state == motion_pkg::DDA_RUN) |-> (clk_cnt <= divisor));

endmodule

`default_nettype wire

//--- design/hbridge_phase.sv
`timescale 1ns/1ps
`default_nettype none

module hbridge_phase (
  input  wire logic CLK,
  input  wire logic reset,
  input  wire logic step,
  input  wire logic dir,
  input  wire logic enable,
  input  wire motion_pkg::ustep_t microsteps,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  logic [2:0] phase_idx;
  logic [2:0] stride;
  // Drive pattern as {a1, a2, b1, b2}
  logic [3:0] coils;

  // Half step walks every state, full step every other
  assign stride = (microsteps == 3'd2) ? 3'd1 : 3'd2;

  always_ff @(posedge CLK) begin
    if (reset) begin
      phase_idx <= 3'd0;
    end else if (enable && step) begin
      phase_idx <= dir ? phase_idx + stride : phase_idx - stride;
    end
  end

  // Even states energize both windings
  always_comb begin
    case (phase_idx)
      3'd0:    coils = 4'b1010;
      3'd1:    coils = 4'b0010;
      3'd2:    coils = 4'b0110;
      3'd3:    coils = 4'b0100;
      3'd4:    coils = 4'b0101;
      3'd5:    coils = 4'b0001;
      3'd6:    coils = 4'b1001;
      default: coils = 4'b1000;
    endcase
  end

  // Disabled bridge floats both windings
  assign {phase_a1, phase_a2, phase_b1, phase_b2} = enable ? coils : 4'b0000;

endmodule

`default_nettype wire

//--- design/quad_counter.sv
`timescale 1ns/1ps
`default_nettype none

module quad_counter (
  input  wire logic CLK,
  input  wire logic reset,
  input  wire logic enc_a,
  input  wire logic enc_b,
  output motion_pkg::enc_count_t count,
  output logic fault
);

  // Two sync flops, third holds the previous sample
  logic [2:0] a_s;
  logic [2:0] b_s;
  // Gray code folded to a binary position
  logic [1:0] cur_pos;
  logic [1:0] prev_pos;
  logic [1:0] delta;

  assign cur_pos = {a_s[1], a_s[1] ^ b_s[1]};
  assign prev_pos = {a_s[2], a_s[2] ^ b_s[2]};
  assign delta = cur_pos - prev_pos;

  always_ff @(posedge CLK) begin
    if (reset) begin
      a_s <= '0;
      b_s <= '0;
      count <= '0;
      fault <= 1'b0;
    end else begin
      a_s <= {a_s[1:0], enc_a};
      b_s <= {b_s[1:0], enc_b};
      case (delta)
        2'd1:    count <= count + 1'b1;
        2'd3:    count <= count - 1'b1;
        // Both lines moved, sticky until reset
        2'd2:    fault <= 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/motion_top.sv
`timescale 1ns/1ps
`default_nettype none

module motion_top (
  input  wire logic CLK,
  input  wire logic reset,
  input  wire logic sck,
  input  wire logic cs,
  input  wire logic copi,
  output wire logic cipo,
  input  wire logic enc_a,
  input  wire logic enc_b,
  output wire logic phase_a1,
  output wire logic phase_a2,
  output wire logic phase_b1,
  output wire logic phase_b2,
  output wire logic enc_fault
);

  logic word_valid;
  host_pkg::word_t rx_word;
  host_pkg::word_t tx_word;
  motion_pkg::divisor_t divisor;
  logic enable;
  motion_pkg::ustep_t microsteps;
  motion_pkg::enc_count_t enc_count;
  motion_pkg::enc_count_t enc_last;
  logic step;
  logic dir;

  // Decoder to planner move channel
  move_if mv ();

  spi_word_rx u_spi (.CLK(CLK), .reset(reset), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
                     .tx_word(tx_word), .rx_word(rx_word), .word_valid(word_valid));

  cmd_decoder u_dec (.CLK(CLK), .reset(reset), .word_valid(word_valid), .rx_word(rx_word),
                     .tx_word(tx_word), .mv(mv.source), .divisor(divisor), .enable(enable),
                     .microsteps(microsteps), .enc_count(enc_count), .enc_last(enc_last));

  step_planner u_plan (.CLK(CLK), .reset(reset), .mv(mv.sink), .divisor(divisor),
                       .enc_count(enc_count), .enc_last(enc_last), .step(step), .dir(dir));

  hbridge_phase u_bridge (.CLK(CLK), .reset(reset), .step(step), .dir(dir), .enable(enable),
                          .microsteps(microsteps), .phase_a1(phase_a1), .phase_a2(phase_a2),
                          .phase_b1(phase_b1), .phase_b2(phase_b2));

  quad_counter u_enc (.CLK(CLK), .reset(reset), .enc_a(enc_a), .enc_b(enc_b),
                      .count(enc_count), .fault(enc_fault));

endmodule

`default_nettype wire

//--- verif/motion_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_defs.svh"

module motion_tb;

  logic CLK;
  logic reset;
  logic sck;
  logic cs;
  logic copi;
  logic enc_a;
  logic enc_b;
  wire cipo;
  wire phase_a1;
  wire phase_a2;
  wire phase_b1;
  wire phase_b2;
  wire enc_fault;

  // Scoreboard totals
  int errors = 0;
  int test_errs = 0;
  int tests_run = 0;
  int tests_failed = 0;
  logic [31:0] rng_state = 32'h3619a230;
  // Model of the planner accumulator carried across moves
  motion_pkg::rate_t ref_acc = '0;
  // Encoder position in the Gray cycle and expected net count
  logic [1:0] enc_pos = 2'd0;
  motion_pkg::enc_count_t enc_expect = '0;

  // Phase monitor tallies
  int fwd_moves = 0;
  int rev_moves = 0;
  int half_strides = 0;
  int full_strides = 0;
  int bad_phases = 0;
  int prev_idx = 0;
  bit have_prev = 0;
  int base_fwd;
  int base_rev;
  int base_half;
  int base_full;
  int base_bad;

  motion_top u_dut (.CLK(CLK), .reset(reset), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
                    .enc_a(enc_a), .enc_b(enc_b), .phase_a1(phase_a1), .phase_a2(phase_a2),
                    .phase_b1(phase_b1), .phase_b2(phase_b2), .enc_fault(enc_fault));

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Expected steps of one move from the DDA rule
  function automatic int dda_steps(input motion_pkg::duration_t dur,
                                   input motion_pkg::rate_t incr,
                                   input motion_pkg::rate_t incr2);
    motion_pkg::rate_t rate;
    motion_pkg::duration_t t;
    int steps;
    rate = incr;
    steps = 0;
    // Duration+1 ticks with the rate growing after each
    for (t = 0; t <= dur; t++) begin
      ref_acc = ref_acc + rate;
      if (ref_acc > 0) begin
        steps++;
        ref_acc = ref_acc - motion_pkg::rate_t'(`DDA_THRESHOLD);
      end
      rate = rate + incr2;
    end
    return steps;
  endfunction

  // Winding pattern {a1, a2, b1, b2} back to the eight-state index
  function automatic int phase_index(input logic [3:0] coils);
    case (coils)
      4'b1010: return 0;
      4'b0010: return 1;
      4'b0110: return 2;
      4'b0100: return 3;
      4'b0101: return 4;
      4'b0001: return 5;
      4'b1001: return 6;
      4'b1000: return 7;
      default: return -1;
    endcase
  endfunction

  // Phase changes sampled away from the active edge
  always @(negedge CLK) begin : phase_monitor
    logic [3:0] coils;
    int idx;
    int diff;
    coils = {phase_a1, phase_a2, phase_b1, phase_b2};
    idx = phase_index(coils);
    if (reset || coils == 4'b0000) begin
      have_prev = 0;
    end else if (idx < 0) begin
      bad_phases++;
    end else begin
      if (have_prev) begin
        diff = (idx - prev_idx) & 7;
        case (diff)
          0: ;
          1: begin
            fwd_moves++;
            half_strides++;
          end
          2: begin
            fwd_moves++;
            full_strides++;
          end
          6: begin
            rev_moves++;
            full_strides++;
          end
          7: begin
            rev_moves++;
            half_strides++;
          end
          default: bad_phases++;
        endcase
      end
      prev_idx = idx;
      have_prev = 1;
    end
  end

  task automatic mark_monitor();
    base_fwd = fwd_moves;
    base_rev = rev_moves;
    base_half = half_strides;
    base_full = full_strides;
    base_bad = bad_phases;
  endtask

  task automatic check_word(input string name, input host_pkg::word_t got,
                            input host_pkg::word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_count(input string name, input motion_pkg::enc_count_t got,
                             input motion_pkg::enc_count_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_level(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    errors++;
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, test_errs);
    end
    test_errs = 0;
  endtask

  // One full-duplex mode 0 word with an SCK half period of 5 CLK
  task automatic spi_exchange(input host_pkg::word_t out_word, output host_pkg::word_t in_word);
    int i;
    in_word = '0;
    cs = 1'b0;
    repeat (6) next_cycle();
    for (i = `WORD_W - 1; i >= 0; i--) begin
      copi = out_word[i];
      repeat (5) next_cycle();
      // Reply bit settled since the last fall
      in_word[i] = cipo;
      sck = 1'b1;
      repeat (5) next_cycle();
      sck = 1'b0;
    end
    // Hold CS past the word strobe
    repeat (8) next_cycle();
    cs = 1'b1;
    repeat (8) next_cycle();
  endtask

  function automatic host_pkg::word_t cmd_word(input host_pkg::header_t hdr,
                                               input logic [55:0] arg);
    return {hdr, arg};
  endfunction

  task automatic send_move(input logic mdir, input motion_pkg::duration_t dur,
                           input motion_pkg::rate_t incr, input motion_pkg::rate_t incr2);
    host_pkg::word_t rx;
    spi_exchange(cmd_word(host_pkg::CMD_COORD_STEP, {55'd0, mdir}), rx);
    spi_exchange(dur, rx);
    spi_exchange(incr, rx);
    spi_exchange(incr2, rx);
  endtask

  // Gray order 00, 01, 11, 10 on {a, b}
  task automatic enc_steps(input int n, input bit fwd);
    repeat (n) begin
      enc_pos = fwd ? enc_pos + 2'd1 : enc_pos - 2'd1;
      enc_expect = fwd ? enc_expect + 1 : enc_expect - 1;
      {enc_a, enc_b} = {enc_pos[1], enc_pos[1] ^ enc_pos[0]};
      repeat (4) next_cycle();
    end
  endtask

  // Runs until the move time has passed and all advances arrived
  task automatic wait_moves(input int exp_fwd, input int exp_rev, input int min_cycles);
    int n;
    n = 0;
    while ((n < min_cycles || fwd_moves - base_fwd < exp_fwd ||
            rev_moves - base_rev < exp_rev) && n < min_cycles + 400) begin
      next_cycle();
      n++;
    end
    if (fwd_moves - base_fwd < exp_fwd || rev_moves - base_rev < exp_rev) begin
      report_timeout("the phase advances of a move");
    end
  endtask

  initial begin : stimulus
    host_pkg::word_t rx;
    motion_pkg::duration_t d1;
    motion_pkg::duration_t d2;
    motion_pkg::rate_t i1;
    motion_pkg::rate_t i2;
    motion_pkg::rate_t j1;
    motion_pkg::rate_t j2;
    logic mdir;
    int n1;
    int n2;
    int e1;
    int e2;
    int n;
    reset = 1'b1;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    repeat (16) @(posedge CLK);
    #1;
    reset = 1'b0;
    repeat (4) next_cycle();

    // Version word comes back during the trailer
    spi_exchange(cmd_word(host_pkg::CMD_API_VERSION, 56'd0), rx);
    spi_exchange(cmd_word(8'h00, 56'd0), rx);
    check_word("version reply", rx,
               (host_pkg::word_t'(`VER_MAJOR) << 16) | (host_pkg::word_t'(`VER_MINOR) << 8) |
               host_pkg::word_t'(`VER_PATCH));
    finish_test("version");

    // Random walk then read the count back
    n1 = next_rand() % 50;
    n2 = next_rand() % 50;
    enc_steps(n1, 1'b1);
    enc_steps(n2, 1'b0);
    repeat (8) next_cycle();
    spi_exchange(cmd_word(8'h00, 56'd0), rx);
    check_count("encoder count", motion_pkg::enc_count_t'(rx), enc_expect);
    finish_test("encoder count");

    // Both lines at once is illegal
    check_level("enc_fault", {3'b0, enc_fault}, 4'h0);
    enc_pos = enc_pos + 2'd2;
    {enc_a, enc_b} = ~{enc_a, enc_b};
    n = 0;
    while (enc_fault !== 1'b1 && n < 20) begin
      next_cycle();
      n++;
    end
    if (enc_fault !== 1'b1) begin
      report_timeout("enc_fault to rise");
    end
    enc_steps(3, 1'b1);
    repeat (10) next_cycle();
    check_level("enc_fault", {3'b0, enc_fault}, 4'h1);
    finish_test("encoder fault");

    // Full step at divisor 3 in a random direction
    spi_exchange(cmd_word(host_pkg::CMD_MOTOR_ENABLE, 56'd1), rx);
    spi_exchange(cmd_word(host_pkg::CMD_CLK_DIVISOR, 56'd3), rx);
    spi_exchange(cmd_word(host_pkg::CMD_MICROSTEPS, 56'd1), rx);
    mdir = 1'(next_rand());
    d1 = 20 + next_rand() % 20;
    i1 = {3'b001, next_rand(), 29'(next_rand())};
    j1 = {10'd0, 22'(next_rand()), next_rand()};
    e1 = dda_steps(d1, i1, j1);
    mark_monitor();
    send_move(mdir, d1, i1, j1);
    wait_moves(mdir ? e1 : 0, mdir ? 0 : e1, (int'(d1) + 1) * 3 + 10);
    check_count("forward advances", fwd_moves - base_fwd, mdir ? e1 : 0);
    check_count("reverse advances", rev_moves - base_rev, mdir ? 0 : e1);
    check_count("half strides", half_strides - base_half, 0);
    check_count("bad phases", bad_phases - base_bad, 0);
    finish_test("full step move");

    // Half step long forward move with a reverse move queued behind
    spi_exchange(cmd_word(host_pkg::CMD_MICROSTEPS, 56'd2), rx);
    spi_exchange(cmd_word(host_pkg::CMD_CLK_DIVISOR, 56'd20), rx);
    d1 = 180 + next_rand() % 40;
    d2 = 20 + next_rand() % 30;
    i1 = {3'b001, next_rand(), 29'(next_rand())};
    i2 = {3'b001, next_rand(), 29'(next_rand())};
    j1 = {11'd0, 21'(next_rand()), next_rand()};
    j2 = {11'd0, 21'(next_rand()), next_rand()};
    e1 = dda_steps(d1, i1, j1);
    e2 = dda_steps(d2, i2, j2);
    mark_monitor();
    send_move(1'b1, d1, i1, j1);
    send_move(1'b0, d2, i2, j2);
    wait_moves(e1, e2, (int'(d1) + int'(d2) + 2) * 20);
    check_count("forward advances", fwd_moves - base_fwd, e1);
    check_count("reverse advances", rev_moves - base_rev, e2);
    check_count("full strides", full_strides - base_full, 0);
    check_count("bad phases", bad_phases - base_bad, 0);
    finish_test("half step queue");

    // Disabled bridge drives nothing
    spi_exchange(cmd_word(host_pkg::CMD_MOTOR_ENABLE, 56'd0), rx);
    n = 0;
    while ({phase_a1, phase_a2, phase_b1, phase_b2} !== 4'h0 && n < 20) begin
      next_cycle();
      n++;
    end
    if ({phase_a1, phase_a2, phase_b1, phase_b2} !== 4'h0) begin
      report_timeout("the phase outputs to clear");
    end
    check_level("phase outputs", {phase_a1, phase_a2, phase_b1, phase_b2}, 4'h0);
    finish_test("disable");

    $display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/motion_pkg.sv
design/host_pkg.sv
design/move_if.sv
design/spi_word_rx.sv
design/cmd_decoder.sv
design/step_planner.sv
design/hbridge_phase.sv
design/quad_counter.sv
design/motion_top.sv
verif/motion_tb.sv

//--- Bender.yml
package:
  name: motion_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/motion_pkg.sv
      - design/host_pkg.sv
      - design/move_if.sv
      - design/spi_word_rx.sv
      - design/cmd_decoder.sv
      - design/step_planner.sv
      - design/hbridge_phase.sv
      - design/quad_counter.sv
      - design/motion_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/motion_tb.sv
